/* hw/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

  ////////////////////////////////////////
  // Request fields
  ////////////////////////////////////////

  // Address widths
  localparam int VADDR_BITS = 32;
  localparam int PADDR_BITS = 32;

  // Byte length of one host request
  localparam int LEN_BITS = 16;

  // Sideband
  localparam int PID_BITS  = 6;
  localparam int DEST_BITS = 4;

  // Chunk size, sized like a length so it adds and compares cleanly
  localparam logic [LEN_BITS-1:0] PMTU_BYTES = 256;

  ////////////////////////////////////////
  // Paging and TLB geometry
  ////////////////////////////////////////

  // 4 KiB pages
  localparam int PAGE_BITS = 12;
  localparam int VPN_BITS  = VADDR_BITS - PAGE_BITS;
  localparam int PPN_BITS  = PADDR_BITS - PAGE_BITS;

  // Direct mapped, indexed by low vpn bits
  localparam int TLB_IDX_BITS  = 4;
  localparam int N_TLB_ENTRIES = 1 << TLB_IDX_BITS;
  // Rest of the vpn is kept as tag
  localparam int TLB_TAG_BITS  = VPN_BITS - TLB_IDX_BITS;

  // Input request queue
  localparam int REQ_FIFO_DEPTH = 4;

  // Parser FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PARSE,
    ST_SEND
  } parse_state_e;

endpackage

`default_nettype wire

/* hw/tlb_req_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_req_queue (
  input  wire                            aclk,
  input  wire                            aresetn,
  // Write side
  input  wire                            in_valid,
  output logic                           in_ready,
  input  wire [tlb_pkg::LEN_BITS-1:0]    in_len,
  input  wire [tlb_pkg::VADDR_BITS-1:0]  in_vaddr,
  input  wire                            in_ctl,
  input  wire [tlb_pkg::PID_BITS-1:0]    in_pid,
  input  wire [tlb_pkg::DEST_BITS-1:0]   in_dest,
  // Read side, head shown without a read strobe
  output logic                           out_valid,
  input  wire                            out_ready,
  output logic [tlb_pkg::LEN_BITS-1:0]   out_len,
  output logic [tlb_pkg::VADDR_BITS-1:0] out_vaddr,
  output logic                           out_ctl,
  output logic [tlb_pkg::PID_BITS-1:0]   out_pid,
  output logic [tlb_pkg::DEST_BITS-1:0]  out_dest
);

  // Storage, one array per field
  logic [tlb_pkg::LEN_BITS-1:0]   len_mem   [tlb_pkg::REQ_FIFO_DEPTH];
  logic [tlb_pkg::VADDR_BITS-1:0] vaddr_mem [tlb_pkg::REQ_FIFO_DEPTH];
  logic                           ctl_mem   [tlb_pkg::REQ_FIFO_DEPTH];
  logic [tlb_pkg::PID_BITS-1:0]   pid_mem   [tlb_pkg::REQ_FIFO_DEPTH];
  logic [tlb_pkg::DEST_BITS-1:0]  dest_mem  [tlb_pkg::REQ_FIFO_DEPTH];

  // Pointers and fill level
  logic [$clog2(tlb_pkg::REQ_FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(tlb_pkg::REQ_FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(tlb_pkg::REQ_FIFO_DEPTH+1)-1:0] count;

  logic push;
  logic pop;

  // Full stalls the host, empty hides the head
  assign in_ready  = (count != tlb_pkg::REQ_FIFO_DEPTH);
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // Pointer wrap and level
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == tlb_pkg::REQ_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == tlb_pkg::REQ_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps the level
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry write
  always_ff @(posedge aclk) begin
    if (push) begin
      len_mem[wr_ptr]   <= in_len;
      vaddr_mem[wr_ptr] <= in_vaddr;
      ctl_mem[wr_ptr]   <= in_ctl;
      pid_mem[wr_ptr]   <= in_pid;
      dest_mem[wr_ptr]  <= in_dest;
    end
  end

  // Fall-through head
  assign out_len   = len_mem[rd_ptr];
  assign out_vaddr = vaddr_mem[rd_ptr];
  assign out_ctl   = ctl_mem[rd_ptr];
  assign out_pid   = pid_mem[rd_ptr];
  assign out_dest  = dest_mem[rd_ptr];

  // Level bounded by depth across any push/pop history
  a_count_bound: assert property (@(posedge aclk) disable iff (!aresetn)
    count <= tlb_pkg::REQ_FIFO_DEPTH)
    else $error("request queue level above depth");

endmodule

`default_nettype wire

/* hw/tlb_parser.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_parser (
  input  wire                            aclk,
  input  wire                            aresetn,
  // Whole request
  input  wire                            s_valid,
  output logic                           s_ready,
  input  wire [tlb_pkg::LEN_BITS-1:0]    s_len,
  input  wire [tlb_pkg::VADDR_BITS-1:0]  s_vaddr,
  input  wire                            s_ctl,
  input  wire [tlb_pkg::PID_BITS-1:0]    s_pid,
  input  wire [tlb_pkg::DEST_BITS-1:0]   s_dest,
  // One chunk at a time
  output logic                           m_valid,
  input  wire                            m_ready,
  output logic [tlb_pkg::LEN_BITS-1:0]   m_len,
  output logic [tlb_pkg::VADDR_BITS-1:0] m_vaddr,
  output logic                           m_ctl,
  output logic [tlb_pkg::PID_BITS-1:0]   m_pid,
  output logic [tlb_pkg::DEST_BITS-1:0]  m_dest
);

  tlb_pkg::parse_state_e state_q;
  tlb_pkg::parse_state_e state_d;

  // Remaining part of the request
  logic [tlb_pkg::LEN_BITS-1:0]   len_q;
  logic [tlb_pkg::LEN_BITS-1:0]   len_d;
  logic [tlb_pkg::VADDR_BITS-1:0] vaddr_q;
  logic [tlb_pkg::VADDR_BITS-1:0] vaddr_d;
  logic                           ctl_q;
  logic                           ctl_d;
  logic [tlb_pkg::PID_BITS-1:0]   pid_q;
  logic [tlb_pkg::PID_BITS-1:0]   pid_d;
  logic [tlb_pkg::DEST_BITS-1:0]  dest_q;
  logic [tlb_pkg::DEST_BITS-1:0]  dest_d;

  // Chunk being presented
  logic [tlb_pkg::LEN_BITS-1:0]   plen_q;
  logic [tlb_pkg::LEN_BITS-1:0]   plen_d;
  logic [tlb_pkg::VADDR_BITS-1:0] pvaddr_q;
  logic [tlb_pkg::VADDR_BITS-1:0] pvaddr_d;
  logic                           pctl_q;
  logic                           pctl_d;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= tlb_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload, meaningful only once latched
  always_ff @(posedge aclk) begin
    len_q    <= len_d;
    vaddr_q  <= vaddr_d;
    ctl_q    <= ctl_d;
    pid_q    <= pid_d;
    dest_q   <= dest_d;
    plen_q   <= plen_d;
    pvaddr_q <= pvaddr_d;
    pctl_q   <= pctl_d;
  end

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      tlb_pkg::ST_IDLE:  if (s_valid) state_d = tlb_pkg::ST_PARSE;
      tlb_pkg::ST_PARSE: state_d = tlb_pkg::ST_SEND;
      // More bytes left means another cut
      tlb_pkg::ST_SEND:  if (m_ready) state_d = (len_q != '0) ? tlb_pkg::ST_PARSE
                                                              : tlb_pkg::ST_IDLE;
      default:           state_d = tlb_pkg::ST_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_comb begin
    len_d    = len_q;
    vaddr_d  = vaddr_q;
    ctl_d    = ctl_q;
    pid_d    = pid_q;
    dest_d   = dest_q;
    plen_d   = plen_q;
    pvaddr_d = pvaddr_q;
    pctl_d   = pctl_q;
    case (state_q)
      // Latch whole request
      tlb_pkg::ST_IDLE: begin
        if (s_valid) begin
          len_d   = s_len;
          vaddr_d = s_vaddr;
          ctl_d   = s_ctl;
          pid_d   = s_pid;
          dest_d  = s_dest;
        end
      end
      // Cut one chunk off the front
      tlb_pkg::ST_PARSE: begin
        pvaddr_d = vaddr_q;
        if (len_q > tlb_pkg::PMTU_BYTES) begin
          vaddr_d = vaddr_q + tlb_pkg::PMTU_BYTES;
          len_d   = len_q - tlb_pkg::PMTU_BYTES;
          plen_d  = tlb_pkg::PMTU_BYTES;
          // Not last, ctl held back
          pctl_d  = 1'b0;
        end else begin
          len_d  = '0;
          plen_d = len_q;
          pctl_d = ctl_q;
        end
      end
      default: begin
      end
    endcase
  end

  // Handshakes straight from state
  assign s_ready = (state_q == tlb_pkg::ST_IDLE);
  assign m_valid = (state_q == tlb_pkg::ST_SEND);

  assign m_len   = plen_q;
  assign m_vaddr = pvaddr_q;
  assign m_ctl   = pctl_q;
  assign m_pid   = pid_q;
  assign m_dest  = dest_q;

  // Stalled chunk must not change under the consumer
  a_chunk_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> m_valid && $stable({m_len, m_vaddr, m_ctl, m_pid, m_dest}))
    else $error("parser chunk changed while stalled");

  a_chunk_max: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid |-> m_len <= tlb_pkg::PMTU_BYTES)
    else $error("parser chunk longer than PMTU");

endmodule

`default_nettype wire

/* hw/tlb_lookup.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_lookup (
  input  wire                            aclk,
  input  wire                            aresetn,
  // Maintenance pulses
  input  wire                            tlb_wr,
  input  wire [tlb_pkg::VPN_BITS-1:0]    tlb_wr_vpn,
  input  wire [tlb_pkg::PID_BITS-1:0]    tlb_wr_pid,
  input  wire [tlb_pkg::PPN_BITS-1:0]    tlb_wr_ppn,
  input  wire                            tlb_flush,
  // Chunk in
  input  wire                            s_valid,
  output logic                           s_ready,
  input  wire [tlb_pkg::LEN_BITS-1:0]    s_len,
  input  wire [tlb_pkg::VADDR_BITS-1:0]  s_vaddr,
  input  wire                            s_ctl,
  input  wire [tlb_pkg::PID_BITS-1:0]    s_pid,
  input  wire [tlb_pkg::DEST_BITS-1:0]   s_dest,
  // Translated chunk out
  output logic                           m_valid,
  input  wire                            m_ready,
  output logic [tlb_pkg::LEN_BITS-1:0]   m_len,
  output logic [tlb_pkg::VADDR_BITS-1:0] m_vaddr,
  output logic                           m_ctl,
  output logic [tlb_pkg::PID_BITS-1:0]   m_pid,
  output logic [tlb_pkg::DEST_BITS-1:0]  m_dest,
  output logic [tlb_pkg::PADDR_BITS-1:0] m_paddr,
  output logic                           m_hit
);

  // Entry arrays
  logic [tlb_pkg::N_TLB_ENTRIES-1:0] ent_valid;
  logic [tlb_pkg::TLB_TAG_BITS-1:0]  ent_tag [tlb_pkg::N_TLB_ENTRIES];
  logic [tlb_pkg::PID_BITS-1:0]      ent_pid [tlb_pkg::N_TLB_ENTRIES];
  logic [tlb_pkg::PPN_BITS-1:0]      ent_ppn [tlb_pkg::N_TLB_ENTRIES];

  // Write port split
  logic [tlb_pkg::TLB_IDX_BITS-1:0] wr_idx;
  logic [tlb_pkg::TLB_TAG_BITS-1:0] wr_tag;

  // Lookup side
  logic [tlb_pkg::VPN_BITS-1:0]     lk_vpn;
  logic [tlb_pkg::TLB_IDX_BITS-1:0] lk_idx;
  logic [tlb_pkg::TLB_TAG_BITS-1:0] lk_tag;
  logic                             lk_hit;
  logic [tlb_pkg::PADDR_BITS-1:0]   lk_paddr;

  ////////////////////////////////////////
  // Maintenance
  ////////////////////////////////////////

  assign wr_idx = tlb_wr_vpn[tlb_pkg::TLB_IDX_BITS-1:0];
  assign wr_tag = tlb_wr_vpn[tlb_pkg::VPN_BITS-1:tlb_pkg::TLB_IDX_BITS];

  // Flush then write, so a same-cycle write survives
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ent_valid <= '0;
    end else begin
      if (tlb_flush) begin
        ent_valid <= '0;
      end
      if (tlb_wr) begin
        ent_valid[wr_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (tlb_wr) begin
      ent_tag[wr_idx] <= wr_tag;
      ent_pid[wr_idx] <= tlb_wr_pid;
      ent_ppn[wr_idx] <= tlb_wr_ppn;
    end
  end

  ////////////////////////////////////////
  // Translation
  ////////////////////////////////////////

  // Page of the first byte only
  assign lk_vpn = s_vaddr[tlb_pkg::VADDR_BITS-1:tlb_pkg::PAGE_BITS];
  assign lk_idx = lk_vpn[tlb_pkg::TLB_IDX_BITS-1:0];
  assign lk_tag = lk_vpn[tlb_pkg::VPN_BITS-1:tlb_pkg::TLB_IDX_BITS];

  assign lk_hit = ent_valid[lk_idx] && (ent_tag[lk_idx] == lk_tag)
                  && (ent_pid[lk_idx] == s_pid);
  // Miss reports zero
  assign lk_paddr = lk_hit ? {ent_ppn[lk_idx], s_vaddr[tlb_pkg::PAGE_BITS-1:0]} : '0;

  // Single slot, refilled as it drains
  assign s_ready = !m_valid || m_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid <= 1'b0;
    end else if (s_ready) begin
      m_valid <= s_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) begin
      m_len   <= s_len;
      m_vaddr <= s_vaddr;
      m_ctl   <= s_ctl;
      m_pid   <= s_pid;
      m_dest  <= s_dest;
      m_paddr <= lk_paddr;
      m_hit   <= lk_hit;
    end
  end

  // Output held until taken
  a_out_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> m_valid)
    else $error("lookup output dropped before ready");

endmodule

`default_nettype wire

/* hw/tlb_req_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_req_top (
  input  wire                            aclk,
  input  wire                            aresetn,
  // Host requests
  input  wire                            s_req_valid,
  output logic                           s_req_ready,
  input  wire [tlb_pkg::LEN_BITS-1:0]    s_req_len,
  input  wire [tlb_pkg::VADDR_BITS-1:0]  s_req_vaddr,
  input  wire                            s_req_ctl,
  input  wire [tlb_pkg::PID_BITS-1:0]    s_req_pid,
  input  wire [tlb_pkg::DEST_BITS-1:0]   s_req_dest,
  // Translated chunks
  output logic                           m_req_valid,
  input  wire                            m_req_ready,
  output logic [tlb_pkg::LEN_BITS-1:0]   m_req_len,
  output logic [tlb_pkg::VADDR_BITS-1:0] m_req_vaddr,
  output logic                           m_req_ctl,
  output logic [tlb_pkg::PID_BITS-1:0]   m_req_pid,
  output logic [tlb_pkg::DEST_BITS-1:0]  m_req_dest,
  output logic [tlb_pkg::PADDR_BITS-1:0] m_req_paddr,
  output logic                           m_req_hit,
  // TLB maintenance
  input  wire                            tlb_wr,
  input  wire [tlb_pkg::VPN_BITS-1:0]    tlb_wr_vpn,
  input  wire [tlb_pkg::PID_BITS-1:0]    tlb_wr_pid,
  input  wire [tlb_pkg::PPN_BITS-1:0]    tlb_wr_ppn,
  input  wire                            tlb_flush
);

  // Queue to parser
  logic                           q_valid;
  logic                           q_ready;
  logic [tlb_pkg::LEN_BITS-1:0]   q_len;
  logic [tlb_pkg::VADDR_BITS-1:0] q_vaddr;
  logic                           q_ctl;
  logic [tlb_pkg::PID_BITS-1:0]   q_pid;
  logic [tlb_pkg::DEST_BITS-1:0]  q_dest;

  // Parser to lookup
  logic                           c_valid;
  logic                           c_ready;
  logic [tlb_pkg::LEN_BITS-1:0]   c_len;
  logic [tlb_pkg::VADDR_BITS-1:0] c_vaddr;
  logic                           c_ctl;
  logic [tlb_pkg::PID_BITS-1:0]   c_pid;
  logic [tlb_pkg::DEST_BITS-1:0]  c_dest;

  tlb_req_queue u_queue (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (s_req_valid),
    .in_ready  (s_req_ready),
    .in_len    (s_req_len),
    .in_vaddr  (s_req_vaddr),
    .in_ctl    (s_req_ctl),
    .in_pid    (s_req_pid),
    .in_dest   (s_req_dest),
    .out_valid (q_valid),
    .out_ready (q_ready),
    .out_len   (q_len),
    .out_vaddr (q_vaddr),
    .out_ctl   (q_ctl),
    .out_pid   (q_pid),
    .out_dest  (q_dest)
  );

  tlb_parser u_parser (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (q_valid),
    .s_ready (q_ready),
    .s_len   (q_len),
    .s_vaddr (q_vaddr),
    .s_ctl   (q_ctl),
    .s_pid   (q_pid),
    .s_dest  (q_dest),
    .m_valid (c_valid),
    .m_ready (c_ready),
    .m_len   (c_len),
    .m_vaddr (c_vaddr),
    .m_ctl   (c_ctl),
    .m_pid   (c_pid),
    .m_dest  (c_dest)
  );

  tlb_lookup u_lookup (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .tlb_wr     (tlb_wr),
    .tlb_wr_vpn (tlb_wr_vpn),
    .tlb_wr_pid (tlb_wr_pid),
    .tlb_wr_ppn (tlb_wr_ppn),
    .tlb_flush  (tlb_flush),
    .s_valid    (c_valid),
    .s_ready    (c_ready),
    .s_len      (c_len),
    .s_vaddr    (c_vaddr),
    .s_ctl      (c_ctl),
    .s_pid      (c_pid),
    .s_dest     (c_dest),
    .m_valid    (m_req_valid),
    .m_ready    (m_req_ready),
    .m_len      (m_req_len),
    .m_vaddr    (m_req_vaddr),
    .m_ctl      (m_req_ctl),
    .m_pid      (m_req_pid),
    .m_dest     (m_req_dest),
    .m_paddr    (m_req_paddr),
    .m_hit      (m_req_hit)
  );

endmodule

`default_nettype wire

/* dv/tlb_req_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_req_tb;

  localparam int CLK_PERIOD = 40;
  localparam int N_DIRECTED = 15;
  localparam int N_RANDOM   = 60;
  localparam int N_REQS     = N_DIRECTED + N_RANDOM;
  // Per request budget plus a fixed margin for reset and drains
  localparam int TIMEOUT_CYCLES = 40 * N_REQS + 200;

  typedef struct packed {
    logic [tlb_pkg::LEN_BITS-1:0]   len;
    logic [tlb_pkg::VADDR_BITS-1:0] vaddr;
    logic                           ctl;
    logic [tlb_pkg::PID_BITS-1:0]   pid;
    logic [tlb_pkg::DEST_BITS-1:0]  dest;
    logic [tlb_pkg::PADDR_BITS-1:0] paddr;
    logic                           hit;
  } chunk_t;

  logic                           aclk = 1'b0;
  logic                           aresetn;
  logic                           s_req_valid;
  logic                           s_req_ready;
  logic [tlb_pkg::LEN_BITS-1:0]   s_req_len;
  logic [tlb_pkg::VADDR_BITS-1:0] s_req_vaddr;
  logic                           s_req_ctl;
  logic [tlb_pkg::PID_BITS-1:0]   s_req_pid;
  logic [tlb_pkg::DEST_BITS-1:0]  s_req_dest;
  logic                           m_req_valid;
  logic                           m_req_ready;
  logic [tlb_pkg::LEN_BITS-1:0]   m_req_len;
  logic [tlb_pkg::VADDR_BITS-1:0] m_req_vaddr;
  logic                           m_req_ctl;
  logic [tlb_pkg::PID_BITS-1:0]   m_req_pid;
  logic [tlb_pkg::DEST_BITS-1:0]  m_req_dest;
  logic [tlb_pkg::PADDR_BITS-1:0] m_req_paddr;
  logic                           m_req_hit;
  logic                           tlb_wr;
  logic [tlb_pkg::VPN_BITS-1:0]   tlb_wr_vpn;
  logic [tlb_pkg::PID_BITS-1:0]   tlb_wr_pid;
  logic [tlb_pkg::PPN_BITS-1:0]   tlb_wr_ppn;
  logic                           tlb_flush;

  // Expected chunks with the oldest at the front
  chunk_t exp_q[$];
  logic [tlb_pkg::LEN_BITS-1:0]   exp_len;
  logic [tlb_pkg::VADDR_BITS-1:0] exp_vaddr;
  logic                           exp_ctl;
  logic [tlb_pkg::PID_BITS-1:0]   exp_pid;
  logic [tlb_pkg::DEST_BITS-1:0]  exp_dest;
  logic [tlb_pkg::PADDR_BITS-1:0] exp_paddr;
  logic                           exp_hit;
  int                             exp_cnt;

  // Shadow TLB holding the full vpn per slot
  logic [tlb_pkg::N_TLB_ENTRIES-1:0] sh_valid;
  logic [tlb_pkg::VPN_BITS-1:0]      sh_vpn [tlb_pkg::N_TLB_ENTRIES];
  logic [tlb_pkg::PID_BITS-1:0]      sh_pid [tlb_pkg::N_TLB_ENTRIES];
  logic [tlb_pkg::PPN_BITS-1:0]      sh_ppn [tlb_pkg::N_TLB_ENTRIES];

  logic [31:0] lcg_state;
  logic [31:0] rdy_state;
  logic        throttle;
  logic        lat_check;
  string       test_name;

  tlb_req_top u_dut (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_req_len   (s_req_len),
    .s_req_vaddr (s_req_vaddr),
    .s_req_ctl   (s_req_ctl),
    .s_req_pid   (s_req_pid),
    .s_req_dest  (s_req_dest),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_len   (m_req_len),
    .m_req_vaddr (m_req_vaddr),
    .m_req_ctl   (m_req_ctl),
    .m_req_pid   (m_req_pid),
    .m_req_dest  (m_req_dest),
    .m_req_paddr (m_req_paddr),
    .m_req_hit   (m_req_hit),
    .tlb_wr      (tlb_wr),
    .tlb_wr_vpn  (tlb_wr_vpn),
    .tlb_wr_pid  (tlb_wr_pid),
    .tlb_wr_ppn  (tlb_wr_ppn),
    .tlb_flush   (tlb_flush)
  );

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_step(lcg_state);
    return lcg_state;
  endfunction

  task automatic stop_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_value(input string field, input logic [63:0] exp,
                              input logic [63:0] act);
    $display("Fail %s %s expected 0x%0h actual 0x%0h", test_name, field, exp, act);
    stop_with_failure();
  endtask

  // Split rule and translation rule applied to one request
  task automatic push_chunks(input logic [tlb_pkg::LEN_BITS-1:0] len,
                             input logic [tlb_pkg::VADDR_BITS-1:0] vaddr,
                             input logic ctl,
                             input logic [tlb_pkg::PID_BITS-1:0] pid,
                             input logic [tlb_pkg::DEST_BITS-1:0] dest);
    logic [tlb_pkg::LEN_BITS-1:0]     rem;
    logic [tlb_pkg::VADDR_BITS-1:0]   va;
    logic [tlb_pkg::VPN_BITS-1:0]     vpn;
    logic [tlb_pkg::TLB_IDX_BITS-1:0] idx;
    chunk_t                           c;
    rem = len;
    va  = vaddr;
    // Length zero still gives one chunk
    do begin
      c.vaddr = va;
      c.pid   = pid;
      c.dest  = dest;
      if (rem > tlb_pkg::PMTU_BYTES) begin
        c.len = tlb_pkg::PMTU_BYTES;
        c.ctl = 1'b0;
      end else begin
        c.len = rem;
        c.ctl = ctl;
      end
      // Page of the first byte
      vpn     = va[tlb_pkg::VADDR_BITS-1:tlb_pkg::PAGE_BITS];
      idx     = vpn[tlb_pkg::TLB_IDX_BITS-1:0];
      c.hit   = sh_valid[idx] && (sh_vpn[idx] == vpn) && (sh_pid[idx] == pid);
      c.paddr = c.hit ? {sh_ppn[idx], va[tlb_pkg::PAGE_BITS-1:0]} : '0;
      exp_q.push_back(c);
      va  = va + c.len;
      rem = rem - c.len;
    end while (rem != '0);
  endtask

  // Starts right after a rising edge and returns at the handshake edge
  task automatic send_req(input logic [tlb_pkg::LEN_BITS-1:0] len,
                          input logic [tlb_pkg::VADDR_BITS-1:0] vaddr,
                          input logic ctl,
                          input logic [tlb_pkg::PID_BITS-1:0] pid,
                          input logic [tlb_pkg::DEST_BITS-1:0] dest);
    s_req_valid <= 1'b1;
    s_req_len   <= len;
    s_req_vaddr <= vaddr;
    s_req_ctl   <= ctl;
    s_req_pid   <= pid;
    s_req_dest  <= dest;
    do @(posedge aclk); while (!s_req_ready);
    s_req_valid <= 1'b0;
  endtask

  task automatic write_tlb(input logic [tlb_pkg::VPN_BITS-1:0] vpn,
                           input logic [tlb_pkg::PID_BITS-1:0] pid,
                           input logic [tlb_pkg::PPN_BITS-1:0] ppn);
    tlb_wr     <= 1'b1;
    tlb_wr_vpn <= vpn;
    tlb_wr_pid <= pid;
    tlb_wr_ppn <= ppn;
    @(posedge aclk);
    tlb_wr <= 1'b0;
  endtask

  task automatic flush_tlb();
    tlb_flush <= 1'b1;
    @(posedge aclk);
    tlb_flush <= 1'b0;
  endtask

  // Until every expected chunk has left the DUT
  task automatic wait_drain();
    @(posedge aclk);
    while (exp_q.size() != 0 || m_req_valid) @(posedge aclk);
    repeat (2) @(posedge aclk);
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  always @(posedge aclk) begin
    if (!aresetn) begin
      exp_q.delete();
      sh_valid = '0;
    end else begin
      if (m_req_valid && m_req_ready && exp_q.size() != 0) begin
        exp_q.delete(0);
      end
      if (s_req_valid && s_req_ready) begin
        push_chunks(s_req_len, s_req_vaddr, s_req_ctl, s_req_pid, s_req_dest);
      end
      // TLB only touched while drained
      if (tlb_flush) begin
        sh_valid = '0;
      end
      if (tlb_wr) begin
        sh_valid[tlb_wr_vpn[tlb_pkg::TLB_IDX_BITS-1:0]] = 1'b1;
        sh_vpn[tlb_wr_vpn[tlb_pkg::TLB_IDX_BITS-1:0]]   = tlb_wr_vpn;
        sh_pid[tlb_wr_vpn[tlb_pkg::TLB_IDX_BITS-1:0]]   = tlb_wr_pid;
        sh_ppn[tlb_wr_vpn[tlb_pkg::TLB_IDX_BITS-1:0]]   = tlb_wr_ppn;
      end
    end
    // Head seen by the checks at the next edge
    if (exp_q.size() != 0) begin
      exp_len   = exp_q[0].len;
      exp_vaddr = exp_q[0].vaddr;
      exp_ctl   = exp_q[0].ctl;
      exp_pid   = exp_q[0].pid;
      exp_dest  = exp_q[0].dest;
      exp_paddr = exp_q[0].paddr;
      exp_hit   = exp_q[0].hit;
    end
    exp_cnt = exp_q.size();
  end

  // Random output back-pressure from its own LCG state
  always @(posedge aclk) begin
    if (throttle) begin
      rdy_state = lcg_step(rdy_state);
      m_req_ready <= rdy_state[30] | rdy_state[27];
    end else begin
      m_req_ready <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_reset: assert property (@(posedge aclk) $rose(aresetn) |-> !m_req_valid && s_req_ready)
    else begin
      $display("Outputs not idle right after reset");
      stop_with_failure();
    end

  a_order: assert property (@(posedge aclk) disable iff (!aresetn)
    m_req_valid && m_req_ready |-> exp_cnt > 0)
    else begin
      $display("Chunk delivered while none was expected");
      stop_with_failure();
    end

  a_len: assert property (@(posedge aclk) disable iff (!aresetn)
    m_req_valid && m_req_ready |-> m_req_len == exp_len)
    else report_value("len", $sampled(exp_len), $sampled(m_req_len));

  a_vaddr: assert property (@(posedge aclk) disable iff (!aresetn)
    m_req_valid && m_req_ready |-> m_req_vaddr == exp_vaddr)
    else report_value("vaddr", $sampled(exp_vaddr), $sampled(m_req_vaddr));

  a_ctl: assert property (@(posedge aclk) disable iff (!aresetn)
    m_req_valid && m_req_ready |-> m_req_ctl == exp_ctl)
    else report_value("ctl", $sampled(exp_ctl), $sampled(m_req_ctl));

  a_side: assert property (@(posedge aclk) disable iff (!aresetn)
    m_req_valid && m_req_ready |-> {m_req_pid, m_req_dest} == {exp_pid, exp_dest})
    else report_value("pid_dest", $sampled({exp_pid, exp_dest}),
                      $sampled({m_req_pid, m_req_dest}));

  a_xlat: assert property (@(posedge aclk) disable iff (!aresetn)
    m_req_valid && m_req_ready |-> {m_req_hit, m_req_paddr} == {exp_hit, exp_paddr})
    else report_value("hit_paddr", $sampled({exp_hit, exp_paddr}),
                      $sampled({m_req_hit, m_req_paddr}));

  a_stall: assert property (@(posedge aclk) disable iff (!aresetn)
    m_req_valid && !m_req_ready |=> m_req_valid && $stable({m_req_len, m_req_vaddr,
      m_req_ctl, m_req_pid, m_req_dest, m_req_paddr, m_req_hit}))
    else begin
      $display("Output chunk changed or vanished while stalled");
      stop_with_failure();
    end

  // Handshake at edge N on an idle pipeline gives valid at edge N+4
  a_latency: assert property (@(posedge aclk) disable iff (!aresetn)
    lat_check && s_req_valid && s_req_ready |-> ##3 !m_req_valid ##1 m_req_valid)
    else begin
      $display("First chunk did not arrive exactly 4 cycles after the request");
      stop_with_failure();
    end

  ////////////////////////////////////////
  // Watchdog and stimulus
  ////////////////////////////////////////

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run hung", TIMEOUT_CYCLES);
    stop_with_failure();
  end

  initial begin
    logic [31:0] r1;
    logic [31:0] r2;
    aresetn     = 1'b0;
    s_req_valid = 1'b0;
    s_req_len   = '0;
    s_req_vaddr = '0;
    s_req_ctl   = 1'b0;
    s_req_pid   = '0;
    s_req_dest  = '0;
    m_req_ready = 1'b0;
    tlb_wr      = 1'b0;
    tlb_wr_vpn  = '0;
    tlb_wr_pid  = '0;
    tlb_wr_ppn  = '0;
    tlb_flush   = 1'b0;
    throttle    = 1'b0;
    lat_check   = 1'b0;
    lcg_state   = 32'd15794;
    rdy_state   = 32'd15794;
    test_name   = "reset";
    repeat (3) @(posedge aclk);
    aresetn <= 1'b1;
    repeat (2) @(posedge aclk);

    test_name = "latency";
    lat_check <= 1'b1;
    send_req(16'd100, 32'h1000_0040, 1'b1, 6'd3, 4'd2);
    lat_check <= 1'b0;
    wait_drain();

    // Around and across the PMTU boundary
    test_name = "split";
    send_req(16'd256, 32'h2000_0010, 1'b1, 6'd1, 4'd1);
    send_req(16'd257, 32'h2000_0200, 1'b1, 6'd2, 4'd3);
    send_req(16'd1000, 32'h2000_0400, 1'b1, 6'd9, 4'd7);
    send_req(16'd1, 32'h2000_0fff, 1'b0, 6'd4, 4'd15);
    wait_drain();

    test_name = "translate";
    write_tlb(20'h12345, 6'd7, 20'habcde);
    send_req(16'd600, 32'h1234_5100, 1'b1, 6'd7, 4'd5);
    // Wrong pid then an unwritten page
    send_req(16'd300, 32'h1234_5100, 1'b1, 6'd8, 4'd5);
    send_req(16'd40, 32'h1234_6000, 1'b0, 6'd7, 4'd6);
    wait_drain();

    test_name = "flush";
    flush_tlb();
    send_req(16'd600, 32'h1234_5100, 1'b1, 6'd7, 4'd5);
    wait_drain();

    // Slow parser fills the queue behind a throttled output
    test_name = "queue_full";
    throttle <= 1'b1;
    for (int i = 0; i < 6; i++) begin
      send_req(16'd1000, 32'h5000_0000 + i * 32'h1000, i[0], i[5:0], i[3:0]);
    end
    wait_drain();

    // Sixteen pages mapped for pid 5
    test_name = "random";
    for (int i = 0; i < tlb_pkg::N_TLB_ENTRIES; i++) begin
      write_tlb(20'h40000 + i, 6'd5, 20'h80000 + i * 7);
    end
    for (int n = 0; n < N_RANDOM; n++) begin
      r1 = next_rand();
      r2 = next_rand();
      send_req(16'd1 + r1[31:16] % 16'd1000, 32'h4000_0000 + r2[31:16], r1[20],
               r1[22] ? 6'd5 : r1[29:24], r2[15:12]);
    end
    wait_drain();

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hw/tlb_pkg.sv
hw/tlb_req_queue.sv
hw/tlb_parser.sv
hw/tlb_lookup.sv
hw/tlb_req_top.sv
dv/tlb_req_tb.sv

/* Bender.yml */
package:
  name: tlb_req

sources:
  - hw/tlb_pkg.sv
  - hw/tlb_req_queue.sv
  - hw/tlb_parser.sv
  - hw/tlb_lookup.sv
  - hw/tlb_req_top.sv
  - target: test
    files:
      - dv/tlb_req_tb.sv
